// File: rtl/csr_defines.svh
// csr unit widths and reset constants shared by the package and the RTL
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

// datapath
`define CSR_XLEN 32            // data word width
`define CSR_ADDR_W 12          // csr address field of the instruction

// performance counters
`define CSR_CNT_W 64           // full counter width, two words
`define CSR_NUM_CNT 2          // mcycle and minstret

// reset values
`define CSR_TRAP_ADDRESS 32'h0000_1000 // mtvec after reset, direct mode
`define CSR_MPP_MACHINE 2'b11  // only machine mode exists, mpp reads back as 3

`endif

// File: rtl/csr_pkg.sv
// csr package holding the operation, address and trap cause types
`include "csr_defines.svh"

package csr_pkg;

    // funct3 field of a system instruction, bit 2 selects the immediate source
    typedef enum logic [2:0] {
        OP_NONE = 3'b000,
        OP_RW   = 3'b001,
        OP_RS   = 3'b010,
        OP_RC   = 3'b011,
        OP_RWI  = 3'b101,
        OP_RSI  = 3'b110,
        OP_RCI  = 3'b111
    } csr_op_e;

    typedef enum logic [`CSR_ADDR_W-1:0] {
        CSR_MVENDORID     = 12'hF11, // identity registers, all read as zero
        CSR_MARCHID       = 12'hF12,
        CSR_MIMPID        = 12'hF13,
        CSR_MHARTID       = 12'hF14,
        CSR_MSTATUS       = 12'h300, // trap setup
        CSR_MISA          = 12'h301,
        CSR_MIE           = 12'h304,
        CSR_MTVEC         = 12'h305,
        CSR_MCOUNTINHIBIT = 12'h320,
        CSR_MSCRATCH      = 12'h340, // trap handling
        CSR_MEPC          = 12'h341,
        CSR_MCAUSE        = 12'h342,
        CSR_MTVAL         = 12'h343,
        CSR_MIP           = 12'h344,
        CSR_MCYCLE        = 12'hB00, // counters
        CSR_MINSTRET      = 12'hB02,
        CSR_MCYCLEH       = 12'hB80,
        CSR_MINSTRETH     = 12'hB82
    } csr_addr_e;

    // mcause codes, interrupt and exception share a code where the spec does
    typedef enum logic [3:0] {
        CAUSE_NONE        = 4'd0,
        CAUSE_ILLEGAL     = 4'd2,
        CAUSE_EBREAK_MSI  = 4'd3,  // ebreak, or software interrupt with bit 31
        CAUSE_MTI         = 4'd7,  // timer interrupt
        CAUSE_ECALL_MEI   = 4'd11  // ecall, or external interrupt with bit 31
    } trap_cause_e;

    // per counter addresses, index 0 is mcycle, index 1 is minstret
    localparam csr_addr_e cnt_lo_addr [`CSR_NUM_CNT] = '{CSR_MCYCLE, CSR_MINSTRET};
    localparam csr_addr_e cnt_hi_addr [`CSR_NUM_CNT] = '{CSR_MCYCLEH, CSR_MINSTRETH};

endpackage

// File: rtl/csr_access_decode.sv
// csr access decoder, builds the read-modify-write value and qualifies the write
`include "csr_defines.svh"

module csr_access_decode (
    input  logic                  i_is_csr,     // system instruction with a csr op
    input  csr_pkg::csr_op_e      i_funct3,
    input  csr_pkg::csr_addr_e    i_csr_index,
    input  logic [`CSR_XLEN-1:0]  i_rs1,        // register source
    input  logic [`CSR_XLEN-1:0]  i_imm,        // zero extended uimm source
    input  logic [`CSR_XLEN-1:0]  i_rdata,      // current value from read mux
    input  logic                  i_ce,
    input  logic                  i_stall,
    output logic                  o_wr_en,
    output csr_pkg::csr_addr_e    o_wr_addr,
    output logic [`CSR_XLEN-1:0]  o_wr_data
);

    logic [`CSR_XLEN-1:0] operand;

    // funct3[2] picks the immediate form
    assign operand = i_funct3[2] ? i_imm : i_rs1;

    always_comb begin
        unique case (i_funct3)
            csr_pkg::OP_RW,
            csr_pkg::OP_RWI: o_wr_data = operand;              // plain write
            csr_pkg::OP_RS,
            csr_pkg::OP_RSI: o_wr_data = i_rdata | operand;    // set bits
            csr_pkg::OP_RC,
            csr_pkg::OP_RCI: o_wr_data = i_rdata & ~operand;   // clear bits
            default:         o_wr_data = i_rdata;              // no change
        endcase
    end

    // write only on accepted cycles with a real operation
    assign o_wr_en = i_is_csr && (i_funct3 != csr_pkg::OP_NONE) && i_ce && !i_stall;

    assign o_wr_addr = i_csr_index; // every receiver decodes its own addresses

endmodule

// File: rtl/csr_perf_counter.sv
// 64-bit performance counter with half word writes and an inhibit bit
`include "csr_defines.svh"

module csr_perf_counter #(
    parameter int IDX      = 0,  // counter number, picks addresses and inhibit bit
    parameter bit FREE_RUN = 1   // 1 counts clocks, 0 counts events
) (
    input  logic                  i_clk,
    input  logic                  i_rst_n,
    input  logic                  i_wr_en,
    input  csr_pkg::csr_addr_e    i_wr_addr,
    input  logic [`CSR_XLEN-1:0]  i_wr_data,
    input  logic                  i_event,      // retire pulse for minstret
    output logic [`CSR_CNT_W-1:0] o_count,
    output logic                  o_inhibit
);

    logic wr_lo;
    logic wr_hi;
    logic wr_inh;
    logic tick;

    assign wr_lo  = i_wr_en && (i_wr_addr == csr_pkg::cnt_lo_addr[IDX]);
    assign wr_hi  = i_wr_en && (i_wr_addr == csr_pkg::cnt_hi_addr[IDX]);
    assign wr_inh = i_wr_en && (i_wr_addr == csr_pkg::CSR_MCOUNTINHIBIT);

    assign tick = !o_inhibit && (FREE_RUN || i_event);

    // no stall input here, counting goes on while the stage is stalled
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_count   <= '0;
            o_inhibit <= 1'b0;
        end else begin
            if (wr_inh)
                o_inhibit <= i_wr_data[2*IDX]; // cy at bit 0, ir at bit 2
            if (wr_lo)
                o_count[`CSR_XLEN-1:0] <= i_wr_data;
            else if (wr_hi)
                o_count[`CSR_CNT_W-1:`CSR_XLEN] <= i_wr_data;
            else if (tick)
                o_count <= o_count + 1'b1;
        end
    end

endmodule

// File: rtl/csr_trap_ctrl.sv
// trap controller, holds trap csrs, detects interrupts and exceptions, drives trap outputs
`include "csr_defines.svh"

module csr_trap_ctrl (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_external_interrupt,
    input  logic                    i_software_interrupt,
    input  logic                    i_timer_interrupt,
    input  logic                    i_is_inst_illegal,
    input  logic                    i_is_ecall,
    input  logic                    i_is_ebreak,
    input  logic                    i_is_mret,
    input  logic [`CSR_XLEN-1:0]    i_pc,
    input  logic                    i_minstret_inc,
    input  logic                    i_ce,
    input  logic                    i_stall,
    input  logic                    i_wr_en,
    input  csr_pkg::csr_addr_e      i_wr_addr,
    input  logic [`CSR_XLEN-1:0]    i_wr_data,
    output logic                    o_mstatus_mie,
    output logic                    o_mstatus_mpie,
    output logic [2:0]              o_mie,          // {meie, mtie, msie}
    output logic [2:0]              o_mip,          // {meip, mtip, msip}
    output logic [`CSR_XLEN-1:0]    o_mtvec,
    output logic [`CSR_XLEN-1:0]    o_mscratch,
    output logic [`CSR_XLEN-1:0]    o_mepc,
    output logic                    o_mcause_int,
    output csr_pkg::trap_cause_e    o_mcause_code,
    output logic [`CSR_XLEN-1:0]    o_mtval,
    output logic                    o_go_to_trap_q,
    output logic                    o_return_from_trap_q,
    output logic [`CSR_XLEN-1:0]    o_trap_address,
    output logic [`CSR_XLEN-1:0]    o_return_address,
    output logic                    o_instret_event
);

    logic [2:0]           int_pend;     // enabled and pending, same order as mie
    logic                 is_exception;
    logic                 go_to_trap;
    logic                 return_from_trap;
    logic                 take_trap;    // first cycle of a trap only
    logic                 trap_int;
    csr_pkg::trap_cause_e trap_cause;
    logic [`CSR_XLEN-1:0] trap_addr;

    assign int_pend     = {3{i_ce && o_mstatus_mie}} & o_mie & o_mip;
    assign is_exception = i_ce && (i_is_inst_illegal || i_is_ecall || i_is_ebreak);
    assign go_to_trap   = (|int_pend) || is_exception;
    assign return_from_trap = i_ce && i_is_mret;
    assign take_trap    = go_to_trap && !o_go_to_trap_q;

    // cause priority: external, software, timer, illegal, ecall, ebreak
    always_comb begin
        trap_int   = 1'b1;
        trap_cause = csr_pkg::CAUSE_NONE;
        if (int_pend[2])            trap_cause = csr_pkg::CAUSE_ECALL_MEI;
        else if (int_pend[0])       trap_cause = csr_pkg::CAUSE_EBREAK_MSI;
        else if (int_pend[1])       trap_cause = csr_pkg::CAUSE_MTI;
        else begin
            trap_int = 1'b0;
            if (i_is_inst_illegal)  trap_cause = csr_pkg::CAUSE_ILLEGAL;
            else if (i_is_ecall)    trap_cause = csr_pkg::CAUSE_ECALL_MEI;
            else if (i_is_ebreak)   trap_cause = csr_pkg::CAUSE_EBREAK_MSI;
        end
    end

    // vectored mode offsets interrupts only, exceptions go to the base
    assign trap_addr = {o_mtvec[`CSR_XLEN-1:2], 2'b00}
                     + ((o_mtvec[0] && trap_int) ? {26'd0, trap_cause, 2'b00} : '0);

    // retire events during a trap or return are not counted
    assign o_instret_event = i_minstret_inc && !o_go_to_trap_q && !o_return_from_trap_q;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mstatus_mie        <= 1'b0;
            o_mstatus_mpie       <= 1'b0;
            o_mie                <= '0;
            o_mip                <= '0;
            o_mtvec              <= `CSR_TRAP_ADDRESS;
            o_mscratch           <= '0;
            o_mepc               <= '0;
            o_mcause_int         <= 1'b0;
            o_mcause_code        <= csr_pkg::CAUSE_NONE;
            o_mtval              <= '0;
            o_go_to_trap_q       <= 1'b0;
            o_return_from_trap_q <= 1'b0;
            o_trap_address       <= '0;
            o_return_address     <= '0;
        end else if (!i_stall) begin
            // mstatus, software write wins over trap entry and mret
            if (i_wr_en && i_wr_addr == csr_pkg::CSR_MSTATUS) begin
                o_mstatus_mie  <= i_wr_data[3];
                o_mstatus_mpie <= i_wr_data[7];
            end else if (take_trap) begin
                o_mstatus_mpie <= o_mstatus_mie;
                o_mstatus_mie  <= 1'b0;          // no nesting
            end else if (return_from_trap) begin
                o_mstatus_mie  <= o_mstatus_mpie;
                o_mstatus_mpie <= 1'b1;
            end
            if (i_wr_en && i_wr_addr == csr_pkg::CSR_MIE)
                o_mie <= {i_wr_data[11], i_wr_data[7], i_wr_data[3]};
            if (i_wr_en && i_wr_addr == csr_pkg::CSR_MTVEC)
                o_mtvec <= i_wr_data;
            if (i_wr_en && i_wr_addr == csr_pkg::CSR_MSCRATCH)
                o_mscratch <= i_wr_data;
            if (i_wr_en && i_wr_addr == csr_pkg::CSR_MTVAL)
                o_mtval <= i_wr_data;
            // mepc and mcause, trap entry wins over software
            if (take_trap)
                o_mepc <= i_pc;
            else if (i_wr_en && i_wr_addr == csr_pkg::CSR_MEPC)
                o_mepc <= {i_wr_data[`CSR_XLEN-1:2], 2'b00};  // word aligned
            if (take_trap) begin
                o_mcause_int  <= trap_int;
                o_mcause_code <= trap_cause;
            end else if (i_wr_en && i_wr_addr == csr_pkg::CSR_MCAUSE) begin
                o_mcause_int  <= i_wr_data[31];
                o_mcause_code <= csr_pkg::trap_cause_e'(i_wr_data[3:0]);
            end
            o_mip <= {i_external_interrupt, i_timer_interrupt, i_software_interrupt};
            if (i_ce) begin
                o_go_to_trap_q       <= go_to_trap;
                o_return_from_trap_q <= return_from_trap;
                o_trap_address       <= trap_addr;
                o_return_address     <= o_mepc;
            end else begin
                o_go_to_trap_q       <= 1'b0;    // flush drops a pending redirect
                o_return_from_trap_q <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/csr_read_mux.sv
// csr read multiplexer, assembles the addressed register and registers the result
`include "csr_defines.svh"

module csr_read_mux (
    input  logic                                    i_clk,
    input  logic                                    i_rst_n,
    input  logic                                    i_ce,
    input  logic                                    i_stall,
    input  csr_pkg::csr_addr_e                      i_csr_index,
    input  logic                                    i_mstatus_mie,
    input  logic                                    i_mstatus_mpie,
    input  logic [2:0]                              i_mie,
    input  logic [2:0]                              i_mip,
    input  logic [`CSR_XLEN-1:0]                    i_mtvec,
    input  logic [`CSR_XLEN-1:0]                    i_mscratch,
    input  logic [`CSR_XLEN-1:0]                    i_mepc,
    input  logic                                    i_mcause_int,
    input  csr_pkg::trap_cause_e                    i_mcause_code,
    input  logic [`CSR_XLEN-1:0]                    i_mtval,
    input  logic [`CSR_NUM_CNT-1:0][`CSR_CNT_W-1:0] i_cnt_value,
    input  logic [`CSR_NUM_CNT-1:0]                 i_cnt_inhibit,
    output logic [`CSR_XLEN-1:0]                    o_rdata,    // to decoder, same cycle
    output logic [`CSR_XLEN-1:0]                    o_csr_out   // to writeback, registered
);

    always_comb begin
        o_rdata = '0;  // identity registers and unknown addresses read zero
        case (i_csr_index)
            csr_pkg::CSR_MSTATUS: begin
                o_rdata[3]     = i_mstatus_mie;
                o_rdata[7]     = i_mstatus_mpie;
                o_rdata[12:11] = `CSR_MPP_MACHINE;
            end
            csr_pkg::CSR_MISA:     o_rdata = 32'h4000_0100; // mxl 1, I only
            csr_pkg::CSR_MIE:      {o_rdata[11], o_rdata[7], o_rdata[3]} = i_mie;
            csr_pkg::CSR_MIP:      {o_rdata[11], o_rdata[7], o_rdata[3]} = i_mip;
            csr_pkg::CSR_MTVEC:    o_rdata = i_mtvec;
            csr_pkg::CSR_MSCRATCH: o_rdata = i_mscratch;
            csr_pkg::CSR_MEPC:     o_rdata = i_mepc;
            csr_pkg::CSR_MCAUSE: begin
                o_rdata[31]  = i_mcause_int;
                o_rdata[3:0] = i_mcause_code;
            end
            csr_pkg::CSR_MTVAL:    o_rdata = i_mtval;
            default: ;
        endcase
        // counter halves and inhibit bits, one slot per counter
        for (int k = 0; k < `CSR_NUM_CNT; k++) begin
            if (i_csr_index == csr_pkg::cnt_lo_addr[k])
                o_rdata = i_cnt_value[k][`CSR_XLEN-1:0];
            if (i_csr_index == csr_pkg::cnt_hi_addr[k])
                o_rdata = i_cnt_value[k][`CSR_CNT_W-1:`CSR_XLEN];
            if (i_csr_index == csr_pkg::CSR_MCOUNTINHIBIT)
                o_rdata[2*k] = i_cnt_inhibit[k];  // bits 0 and 2
        end
    end

    // old value goes out one cycle after the access is accepted
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            o_csr_out <= '0;
        else if (i_ce && !i_stall)
            o_csr_out <= o_rdata;
    end

endmodule

// File: rtl/csr_unit.sv
// machine mode csr unit, one pipeline stage with decoder, counters, trap control and read mux
`include "csr_defines.svh"

module csr_unit (
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  logic                 i_external_interrupt,
    input  logic                 i_software_interrupt,
    input  logic                 i_timer_interrupt,
    input  logic                 i_is_inst_illegal,
    input  logic                 i_is_ecall,
    input  logic                 i_is_ebreak,
    input  logic                 i_is_mret,
    input  logic                 i_is_csr,
    input  csr_pkg::csr_op_e     i_funct3,
    input  csr_pkg::csr_addr_e   i_csr_index,
    input  logic [`CSR_XLEN-1:0] i_rs1,
    input  logic [`CSR_XLEN-1:0] i_imm,
    input  logic [`CSR_XLEN-1:0] i_pc,
    input  logic                 i_minstret_inc,
    input  logic                 i_ce,           // stage enable
    input  logic                 i_stall,        // hold this stage
    output logic [`CSR_XLEN-1:0] o_csr_out,
    output logic [`CSR_XLEN-1:0] o_trap_address,
    output logic [`CSR_XLEN-1:0] o_return_address,
    output logic                 o_go_to_trap_q,
    output logic                 o_return_from_trap_q
);

    logic                                    wr_en;
    csr_pkg::csr_addr_e                      wr_addr;
    logic [`CSR_XLEN-1:0]                    wr_data;
    logic [`CSR_XLEN-1:0]                    rdata;
    logic [`CSR_NUM_CNT-1:0][`CSR_CNT_W-1:0] cnt_value;
    logic [`CSR_NUM_CNT-1:0]                 cnt_inhibit;
    logic                                    instret_event;
    logic                                    mstatus_mie, mstatus_mpie;
    logic [2:0]                              mie, mip;
    logic [`CSR_XLEN-1:0]                    mtvec, mscratch, mepc, mtval;
    logic                                    mcause_int;
    csr_pkg::trap_cause_e                    mcause_code;

    csr_access_decode u_decode (
        .i_is_csr(i_is_csr), .i_funct3(i_funct3), .i_csr_index(i_csr_index),
        .i_rs1(i_rs1), .i_imm(i_imm), .i_rdata(rdata), .i_ce(i_ce), .i_stall(i_stall),
        .o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_data(wr_data)
    );

    // counter 0 is mcycle, counter 1 is minstret
    for (genvar g = 0; g < `CSR_NUM_CNT; g++) begin : g_cnt
        csr_perf_counter #(.IDX(g), .FREE_RUN(g == 0)) u_cnt (
            .i_clk(i_clk), .i_rst_n(i_rst_n), .i_wr_en(wr_en), .i_wr_addr(wr_addr),
            .i_wr_data(wr_data), .i_event(instret_event),
            .o_count(cnt_value[g]), .o_inhibit(cnt_inhibit[g])
        );
    end

    csr_trap_ctrl u_trap (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_external_interrupt(i_external_interrupt),
        .i_software_interrupt(i_software_interrupt), .i_timer_interrupt(i_timer_interrupt),
        .i_is_inst_illegal(i_is_inst_illegal), .i_is_ecall(i_is_ecall),
        .i_is_ebreak(i_is_ebreak), .i_is_mret(i_is_mret), .i_pc(i_pc),
        .i_minstret_inc(i_minstret_inc), .i_ce(i_ce), .i_stall(i_stall),
        .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
        .o_mstatus_mie(mstatus_mie), .o_mstatus_mpie(mstatus_mpie), .o_mie(mie), .o_mip(mip),
        .o_mtvec(mtvec), .o_mscratch(mscratch), .o_mepc(mepc), .o_mcause_int(mcause_int),
        .o_mcause_code(mcause_code), .o_mtval(mtval),
        .o_go_to_trap_q(o_go_to_trap_q), .o_return_from_trap_q(o_return_from_trap_q),
        .o_trap_address(o_trap_address), .o_return_address(o_return_address),
        .o_instret_event(instret_event)
    );

    csr_read_mux u_rmux (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_ce(i_ce), .i_stall(i_stall),
        .i_csr_index(i_csr_index), .i_mstatus_mie(mstatus_mie),
        .i_mstatus_mpie(mstatus_mpie), .i_mie(mie), .i_mip(mip), .i_mtvec(mtvec),
        .i_mscratch(mscratch), .i_mepc(mepc), .i_mcause_int(mcause_int),
        .i_mcause_code(mcause_code), .i_mtval(mtval), .i_cnt_value(cnt_value),
        .i_cnt_inhibit(cnt_inhibit), .o_rdata(rdata), .o_csr_out(o_csr_out)
    );

endmodule

// File: testbench/tb_csr_model.svh
// reference model of the csr unit, expected csr values and trap results
`ifndef TB_CSR_MODEL_SVH
`define TB_CSR_MODEL_SVH

// model copy of the trap state
logic        m_mie;          // mstatus.mie
logic        m_mpie;         // mstatus.mpie
logic [31:0] m_mepc;
logic [31:0] m_mtvec;

// write, set or clear as the funct3 field asks
function automatic logic [31:0] apply_csr_op(input csr_pkg::csr_op_e op,
                                             input logic [31:0] old_val,
                                             input logic [31:0] operand);
    case (op)
        csr_pkg::OP_RW, csr_pkg::OP_RWI: return operand;
        csr_pkg::OP_RS, csr_pkg::OP_RSI: return old_val | operand;
        csr_pkg::OP_RC, csr_pkg::OP_RCI: return old_val & ~operand;
        default:                         return old_val;
    endcase
endfunction

// mstatus as software reads it, mpp fixed to machine
function automatic logic [31:0] mstatus_word(input logic mie, input logic mpie);
    logic [31:0] w;
    w        = 32'h0000_1800;
    w[3]     = mie;
    w[7]     = mpie;
    return w;
endfunction

function automatic logic [31:0] mcause_word(input logic is_int, input logic [3:0] code);
    return {is_int, 27'd0, code};
endfunction

// base, plus 4*cause for interrupts in vectored mode
function automatic logic [31:0] trap_target(input logic [31:0] mtvec,
                                            input logic is_int,
                                            input logic [3:0] code);
    logic [31:0] base;
    base = {mtvec[31:2], 2'b00};
    if (mtvec[0] && is_int)
        return base + {26'd0, code, 2'b00};
    return base;
endfunction

// trap entry saves mie and the pc
function automatic void model_trap_entry(input logic [31:0] pc);
    m_mpie = m_mie;
    m_mie  = 1'b0;
    m_mepc = pc;
endfunction

function automatic void model_mret();
    m_mie  = m_mpie;
    m_mpie = 1'b1;
endfunction

`endif

// File: testbench/tb_csr_unit.sv
// testbench for the csr unit with directed and random csr accesses, counters and traps
`include "csr_defines.svh"

module tb_csr_unit;

    localparam int TOTAL_CYCLES = 220;       // rough sum of all test lengths
    localparam int CLK_PERIOD   = 4;
    localparam int MAX_WAIT     = 10;        // cycles to wait for a trap flag

    logic i_clk, i_rst_n;
    logic i_external_interrupt, i_software_interrupt, i_timer_interrupt;
    logic i_is_inst_illegal, i_is_ecall, i_is_ebreak, i_is_mret, i_is_csr;
    csr_pkg::csr_op_e   i_funct3;
    csr_pkg::csr_addr_e i_csr_index;
    logic [31:0] i_rs1, i_imm, i_pc;
    logic i_minstret_inc, i_ce, i_stall;
    logic [31:0] o_csr_out, o_trap_address, o_return_address;
    logic o_go_to_trap_q, o_return_from_trap_q;

    string       name_q[$];
    logic [31:0] exp_q[$];
    logic [31:0] act_q[$];
    int pending = 0;
    int errors = 0, checks = 0, test_errors = 0, test_checks = 0, tests = 0;

    `include "tb_csr_model.svh"

    csr_unit UUT (.*);

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // compare process draining the queues of expected and actual values
    initial begin
        string       n;
        logic [31:0] e, a;
        forever begin
            wait (pending != 0);
            n = name_q.pop_front();
            e = exp_q.pop_front();
            a = act_q.pop_front();
            checks++;
            test_checks++;
            assert (a == e) else begin
                $display("Fail %s expected 0x%08h actual 0x%08h", n, e, a);
                errors++;
                test_errors++;
            end
            pending--;
        end
    end

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD + 400);
        $display("watchdog: simulation ran past its time limit, a test is stuck");
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_value(input string n, input logic [31:0] e, input logic [31:0] a);
        name_q.push_back(n);
        exp_q.push_back(e);
        act_q.push_back(a);
        pending++;
    endtask

    task automatic end_test(input string n);
        wait (pending == 0);
        tests++;
        $display("test %s done, %0d checks, %0d errors", n, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // one accepted access started 1 unit after a rising edge and returning the old value
    task automatic csr_access(input csr_pkg::csr_op_e op, input csr_pkg::csr_addr_e addr,
                              input logic [31:0] val, output logic [31:0] old_val);
        i_is_csr    = (op != csr_pkg::OP_NONE);
        i_funct3    = op;
        i_csr_index = addr;
        i_rs1       = op[2] ? ~val : val;  // unused source gets the inverted value
        i_imm       = op[2] ? val : ~val;
        @(posedge i_clk);
        #1;
        old_val  = o_csr_out;  // registered read of the accepted cycle
        i_is_csr = 1'b0;
        i_funct3 = csr_pkg::OP_NONE;
    endtask

    task automatic csr_read_check(input string n, input csr_pkg::csr_addr_e addr,
                                  input logic [31:0] e);
        logic [31:0] v;
        csr_access(csr_pkg::OP_NONE, addr, 32'd0, v);
        check_value(n, e, v);
    endtask

    // counts edges until a trap flag shows up or MAX_WAIT runs out
    task automatic wait_flag(input bit want_ret, output int cnt);
        cnt = 0;
        do begin
            @(posedge i_clk);
            #1;
            cnt++;
        end while (!(want_ret ? o_return_from_trap_q : o_go_to_trap_q) && cnt < MAX_WAIT);
    endtask

    initial begin
        csr_pkg::csr_op_e   ops[6] = '{csr_pkg::OP_RW, csr_pkg::OP_RS, csr_pkg::OP_RC,
                                       csr_pkg::OP_RWI, csr_pkg::OP_RSI, csr_pkg::OP_RCI};
        csr_pkg::csr_addr_e tgt[3] = '{csr_pkg::CSR_MSCRATCH, csr_pkg::CSR_MTVAL,
                                       csr_pkg::CSR_MTVEC};
        logic [31:0] model_reg[3];
        logic [31:0] v, opnd, cyc, ins, base;
        csr_pkg::csr_op_e op;
        int k, t, n_inc, cnt;

        void'($urandom(32'he7e9));
        {i_external_interrupt, i_software_interrupt, i_timer_interrupt} = 3'b000;
        {i_is_inst_illegal, i_is_ecall, i_is_ebreak, i_is_mret, i_is_csr} = 5'b0;
        i_funct3 = csr_pkg::OP_NONE;
        i_csr_index = csr_pkg::CSR_MVENDORID;
        {i_rs1, i_imm, i_pc} = '0;
        i_minstret_inc = 1'b0;
        i_ce    = 1'b1;
        i_stall = 1'b0;
        i_rst_n = 1'b0;
        m_mie   = 1'b0;
        m_mpie  = 1'b0;
        m_mepc  = '0;
        m_mtvec = `CSR_TRAP_ADDRESS;
        repeat (3) @(posedge i_clk);
        #1 i_rst_n = 1'b1;

        // reset values
        csr_read_check("reset_mstatus", csr_pkg::CSR_MSTATUS, mstatus_word(m_mie, m_mpie));
        csr_read_check("reset_misa", csr_pkg::CSR_MISA, 32'h4000_0100);
        csr_read_check("reset_mtvec", csr_pkg::CSR_MTVEC, m_mtvec);
        csr_read_check("reset_mvendorid", csr_pkg::CSR_MVENDORID, 32'd0);
        check_value("reset_trap_flags", 32'd0, {30'd0, o_go_to_trap_q, o_return_from_trap_q});
        end_test("reset_values");

        // random operations against the model copies
        model_reg = '{32'd0, 32'd0, `CSR_TRAP_ADDRESS};
        for (int i = 0; i < 40; i++) begin
            op   = ops[$urandom % 6];
            t    = $urandom % 3;
            opnd = $urandom;
            if (op[2])
                opnd = opnd & 32'h1f;  // uimm field is five bits
            csr_access(op, tgt[t], opnd, v);
            check_value("csr_ops", model_reg[t], v);
            model_reg[t] = apply_csr_op(op, model_reg[t], opnd);
        end
        m_mtvec = model_reg[2];
        end_test("csr_operations");

        // both counters inhibited while written and read back
        cyc = $urandom;
        ins = $urandom & 32'h7fff_ffff;  // no carry into the upper half
        csr_access(csr_pkg::OP_RW, csr_pkg::CSR_MCOUNTINHIBIT, 32'h5, v);
        csr_access(csr_pkg::OP_RW, csr_pkg::CSR_MCYCLE, cyc, v);
        csr_access(csr_pkg::OP_RW, csr_pkg::CSR_MINSTRET, ins, v);
        i_minstret_inc = 1'b1;  // retire pulses that the inhibit bit must block
        csr_read_check("mcycle_hold", csr_pkg::CSR_MCYCLE, cyc);
        csr_read_check("mcycle_hold", csr_pkg::CSR_MCYCLE, cyc);
        csr_read_check("minstret_hold", csr_pkg::CSR_MINSTRET, ins);
        csr_read_check("mcountinhibit", csr_pkg::CSR_MCOUNTINHIBIT, 32'h5);
        i_minstret_inc = 1'b0;
        opnd = $urandom;
        csr_access(csr_pkg::OP_RW, csr_pkg::CSR_MCYCLEH, opnd, v);
        csr_read_check("mcycleh", csr_pkg::CSR_MCYCLEH, opnd);
        base = $urandom;
        csr_access(csr_pkg::OP_RW, csr_pkg::CSR_MINSTRETH, base, v);
        csr_read_check("minstreth", csr_pkg::CSR_MINSTRETH, base);
        csr_access(csr_pkg::OP_RC, csr_pkg::CSR_MCOUNTINHIBIT, 32'h4, v);  // ir back on
        n_inc = 5 + ($urandom % 8);
        i_minstret_inc = 1'b1;
        repeat (n_inc) @(posedge i_clk);
        #1 i_minstret_inc = 1'b0;
        csr_read_check("minstret_count", csr_pkg::CSR_MINSTRET, ins + n_inc);
        csr_read_check("minstreth_after", csr_pkg::CSR_MINSTRETH, base);
        csr_read_check("mcycle_inhibited", csr_pkg::CSR_MCYCLE, cyc);
        end_test("counters");

        // timer interrupt in vectored mode
        m_mtvec = 32'h0000_2000 | 32'h1;
        csr_access(csr_pkg::OP_RW, csr_pkg::CSR_MIE, 32'h80, v);   // mtie
        csr_access(csr_pkg::OP_RW, csr_pkg::CSR_MTVEC, m_mtvec, v);
        csr_access(csr_pkg::OP_RW, csr_pkg::CSR_MSTATUS, 32'h8, v);
        m_mie  = 1'b1;
        m_mpie = 1'b0;
        i_pc = $urandom & 32'hffff_fffc;
        i_timer_interrupt = 1'b1;
        wait_flag(1'b0, cnt);
        check_value("irq_latency", 32'd2, cnt);
        check_value("irq_trap_address", trap_target(m_mtvec, 1'b1, 4'd7), o_trap_address);
        i_timer_interrupt = 1'b0;
        model_trap_entry(i_pc);
        csr_read_check("irq_mcause", csr_pkg::CSR_MCAUSE, mcause_word(1'b1, 4'd7));
        csr_read_check("irq_mepc", csr_pkg::CSR_MEPC, m_mepc);
        csr_read_check("irq_mstatus", csr_pkg::CSR_MSTATUS, mstatus_word(m_mie, m_mpie));
        end_test("interrupt_trap");

        // all three exceptions together and then ecall with ebreak
        for (k = 0; k < 2; k++) begin
            i_pc = $urandom & 32'hffff_fffc;
            i_is_inst_illegal = (k == 0);
            i_is_ecall  = 1'b1;
            i_is_ebreak = 1'b1;
            wait_flag(1'b0, cnt);
            check_value("exc_latency", 32'd1, cnt);
            check_value("exc_trap_address",
                        trap_target(m_mtvec, 1'b0, (k == 0) ? 4'd2 : 4'd11), o_trap_address);
            {i_is_inst_illegal, i_is_ecall, i_is_ebreak} = 3'b000;
            model_trap_entry(i_pc);
            csr_read_check("exc_mcause", csr_pkg::CSR_MCAUSE,
                           mcause_word(1'b0, (k == 0) ? 4'd2 : 4'd11));
            csr_read_check("exc_mepc", csr_pkg::CSR_MEPC, m_mepc);
        end
        end_test("exception_priority");

        // mret with mpie set by software first
        csr_access(csr_pkg::OP_RW, csr_pkg::CSR_MSTATUS, 32'h80, v);
        m_mie  = 1'b0;
        m_mpie = 1'b1;
        i_is_mret = 1'b1;
        wait_flag(1'b1, cnt);
        check_value("mret_latency", 32'd1, cnt);
        check_value("mret_return_address", m_mepc, o_return_address);
        i_is_mret = 1'b0;
        model_mret();
        csr_read_check("mret_mstatus", csr_pkg::CSR_MSTATUS, mstatus_word(m_mie, m_mpie));
        end_test("mret");

        wait (pending == 0);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+rtl
+incdir+testbench
rtl/csr_pkg.sv
rtl/csr_access_decode.sv
rtl/csr_perf_counter.sv
rtl/csr_trap_ctrl.sv
rtl/csr_read_mux.sv
rtl/csr_unit.sv
testbench/tb_csr_unit.sv

// File: run.sh
#!/bin/sh
# build and run the csr unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_csr_unit -o sim_csr_unit

out=$(./obj_dir/sim_csr_unit)
echo "$out"

# the run only counts as passing when the pass line shows up
echo "$out" | grep -q '^TEST PASSED$'
echo "simulation passed"
